// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= rs_core_tb
FILELIST ?= project.f
BUILD ?= obj_dir
LOG ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "=== FAIL ===" $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== common/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

  localparam int word_w = 32;

  localparam int num_regs = 16;
  localparam int reg_w = 4;

  localparam int add_depth = 4;
  localparam int mul_depth = 4;

  // tag is the unit bit followed by the entry index
  localparam int tag_w = 3;
  localparam int idx_w = tag_w - 1;
  localparam logic unit_add = 1'b0;
  localparam logic unit_mul = 1'b1;

  // op_mv with an immediate writes the register at issue
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_mul = 2'd1,
    op_mv  = 2'd2
  } op_t;

  // the entry's ready bit tells which view holds
  typedef union packed {
    logic signed [word_w-1:0] value;
    struct packed {
      logic [word_w-tag_w-1:0] pad;
      logic [tag_w-1:0]        tag;
    } prod;
  } operand_u;

  typedef struct packed {
    logic     busy;
    logic     a_ready;
    logic     b_ready;
    operand_u a;
    operand_u b;
  } entry_t;

endpackage

`default_nettype wire

// ==== design/issue_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_unit (
  input  wire logic                             issue_valid,
  input  wire rs_pkg::op_t                      issue_op,
  input  wire logic [rs_pkg::reg_w-1:0]         issue_dest,
  input  wire logic                             has_imm,
  input  wire logic signed [rs_pkg::word_w-1:0] imm,
  input  wire logic                             a_busy,
  input  wire logic [rs_pkg::tag_w-1:0]         a_tag,
  input  wire logic [rs_pkg::word_w-1:0]        a_value,
  input  wire logic                             b_busy,
  input  wire logic [rs_pkg::tag_w-1:0]         b_tag,
  input  wire logic [rs_pkg::word_w-1:0]        b_value,
  input  wire logic                             add_has_free,
  input  wire logic                             mul_has_free,
  input  wire logic [rs_pkg::idx_w-1:0]         add_free_idx,
  input  wire logic [rs_pkg::idx_w-1:0]         mul_free_idx,
  input  wire logic                             cdb_valid,
  input  wire logic [rs_pkg::tag_w-1:0]         cdb_tag,
  input  wire logic [rs_pkg::word_w-1:0]        cdb_value,
  output logic                                  issue_ready,
  output logic                                  rename_en,
  output logic [rs_pkg::reg_w-1:0]              rename_reg,
  output logic [rs_pkg::tag_w-1:0]              rename_tag,
  output logic                                  imm_wr_en,
  output logic [rs_pkg::reg_w-1:0]              imm_wr_reg,
  output logic signed [rs_pkg::word_w-1:0]      imm_wr_value,
  output logic                                  add_alloc_en,
  output logic                                  mul_alloc_en,
  output rs_pkg::operand_u                      alloc_a,
  output rs_pkg::operand_u                      alloc_b,
  output logic                                  alloc_a_ready,
  output logic                                  alloc_b_ready
);

  import rs_pkg::*;

  logic is_imm_mv;
  logic to_mul;
  logic accept;

  // value if settled or broadcast right now, else the producer tag
  function automatic logic [word_w:0] src_operand(
    input logic              busy,
    input logic [tag_w-1:0]  tag,
    input logic [word_w-1:0] value,
    input logic              fwd_valid,
    input logic [tag_w-1:0]  fwd_tag,
    input logic [word_w-1:0] fwd_value
  );
    operand_u opnd;
    logic     ready;
    opnd = '0;
    ready = 1'b1;
    if (!busy) begin
      opnd.value = value;
    end else if (fwd_valid && fwd_tag == tag) begin
      opnd.value = fwd_value;
    end else begin
      opnd.prod.tag = tag;
      ready = 1'b0;
    end
    return {ready, opnd};
  endfunction

  assign is_imm_mv = issue_op == op_mv && has_imm;
  assign to_mul = issue_op == op_mul;

  assign issue_ready = is_imm_mv || (to_mul ? mul_has_free : add_has_free);
  assign accept = issue_valid && issue_ready;

  assign imm_wr_en = accept && is_imm_mv;
  assign imm_wr_reg = issue_dest;
  assign imm_wr_value = imm;

  assign add_alloc_en = accept && !is_imm_mv && !to_mul;
  assign mul_alloc_en = accept && to_mul;

  assign rename_en = add_alloc_en || mul_alloc_en;
  assign rename_reg = issue_dest;
  assign rename_tag = to_mul ? {unit_mul, mul_free_idx} : {unit_add, add_free_idx};

  always_comb begin
    {alloc_a_ready, alloc_a} = src_operand(a_busy, a_tag, a_value,
                                           cdb_valid, cdb_tag, cdb_value);
    if (issue_op == op_mv) begin
      // register move adds zero
      alloc_b = '0;
      alloc_b_ready = 1'b1;
    end else if (has_imm) begin
      alloc_b = '0;
      alloc_b.value = imm;
      alloc_b_ready = 1'b1;
    end else begin
      {alloc_b_ready, alloc_b} = src_operand(b_busy, b_tag, b_value,
                                             cdb_valid, cdb_tag, cdb_value);
    end
  end

endmodule

`default_nettype wire

// ==== design/mul_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_pipe (
  input  wire logic                             clk,
  input  wire logic                             arst_n,
  input  wire logic                             in_valid,
  input  wire logic [rs_pkg::tag_w-1:0]         in_tag,
  input  wire logic signed [rs_pkg::word_w-1:0] in_a,
  input  wire logic signed [rs_pkg::word_w-1:0] in_b,
  output logic                                  out_valid,
  output logic [rs_pkg::tag_w-1:0]              out_tag,
  output logic [rs_pkg::word_w-1:0]             out_value
);

  import rs_pkg::*;

  logic [2:0] valid_q;
  logic [tag_w-1:0] tag_q [3];
  logic signed [word_w-1:0] s1_a;
  logic signed [word_w-1:0] s1_b;
  logic signed [word_w-1:0] s2_prod;
  logic [word_w-1:0] s3_prod;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], in_valid};
    end
  end

  always_ff @(posedge clk) begin
    tag_q[0] <= in_tag;
    tag_q[1] <= tag_q[0];
    tag_q[2] <= tag_q[1];
    s1_a <= in_a;
    s1_b <= in_b;
    // low word only
    s2_prod <= s1_a * s1_b;
    s3_prod <= s2_prod;
  end

  assign out_valid = valid_q[2];
  assign out_tag = tag_q[2];
  assign out_value = s3_prod;

endmodule

`default_nettype wire

// ==== design/reg_status_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_status_file (
  input  wire logic                           clk,
  input  wire logic                           arst_n,
  input  wire logic [rs_pkg::reg_w-1:0]       src_a,
  input  wire logic [rs_pkg::reg_w-1:0]       src_b,
  input  wire logic                           rename_en,
  input  wire logic [rs_pkg::reg_w-1:0]       rename_reg,
  input  wire logic [rs_pkg::tag_w-1:0]       rename_tag,
  input  wire logic                           imm_wr_en,
  input  wire logic [rs_pkg::reg_w-1:0]       imm_wr_reg,
  input  wire logic signed [rs_pkg::word_w-1:0] imm_wr_value,
  input  wire logic                           cdb_valid,
  input  wire logic [rs_pkg::tag_w-1:0]       cdb_tag,
  input  wire logic [rs_pkg::word_w-1:0]      cdb_value,
  input  wire logic [rs_pkg::reg_w-1:0]       rd_addr,
  output logic                                a_busy,
  output logic [rs_pkg::tag_w-1:0]            a_tag,
  output logic [rs_pkg::word_w-1:0]           a_value,
  output logic                                b_busy,
  output logic [rs_pkg::tag_w-1:0]            b_tag,
  output logic [rs_pkg::word_w-1:0]           b_value,
  output logic                                rd_busy,
  output logic [rs_pkg::word_w-1:0]           rd_value
);

  import rs_pkg::*;

  logic [word_w-1:0] values [num_regs];
  logic [tag_w-1:0]  tags [num_regs];
  logic [num_regs-1:0] busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= '0;
      for (int i = 0; i < num_regs; i++) begin
        values[i] <= '0;
        tags[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_regs; i++) begin
        if (imm_wr_en && imm_wr_reg == reg_w'(i)) begin
          values[i] <= imm_wr_value;
          busy[i] <= 1'b0;
        end else if (rename_en && rename_reg == reg_w'(i)) begin
          // younger producer wins over a result arriving now
          busy[i] <= 1'b1;
          tags[i] <= rename_tag;
        end else if (cdb_valid && busy[i] && tags[i] == cdb_tag) begin
          values[i] <= cdb_value;
          busy[i] <= 1'b0;
        end
      end
    end
  end

  assign a_busy = busy[src_a];
  assign a_tag = tags[src_a];
  assign a_value = values[src_a];

  assign b_busy = busy[src_b];
  assign b_tag = tags[src_b];
  assign b_value = values[src_b];

  assign rd_busy = busy[rd_addr];
  assign rd_value = values[rd_addr];

endmodule

`default_nettype wire

// ==== design/result_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_bus (
  input  wire logic                             clk,
  input  wire logic                             arst_n,
  input  wire logic                             add_valid,
  input  wire logic [rs_pkg::tag_w-1:0]         add_tag,
  input  wire logic signed [rs_pkg::word_w-1:0] add_a,
  input  wire logic signed [rs_pkg::word_w-1:0] add_b,
  input  wire logic                             mul_valid,
  input  wire logic [rs_pkg::tag_w-1:0]         mul_tag,
  input  wire logic [rs_pkg::word_w-1:0]        mul_value,
  output logic                                  add_ready,
  output logic                                  cdb_valid,
  output logic [rs_pkg::tag_w-1:0]              cdb_tag,
  output logic [rs_pkg::word_w-1:0]             cdb_value
);

  import rs_pkg::*;

  logic held_valid;
  logic [tag_w-1:0] held_tag;
  logic [word_w-1:0] held_sum;
  logic held_sent;

  // mul result always owns the bus
  assign held_sent = held_valid && !mul_valid;
  assign add_ready = !held_valid || held_sent;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      held_valid <= 1'b0;
    end else if (add_valid && add_ready) begin
      held_valid <= 1'b1;
    end else if (held_sent) begin
      held_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (add_valid && add_ready) begin
      held_tag <= add_tag;
      held_sum <= add_a + add_b;
    end
  end

  assign cdb_valid = mul_valid || held_valid;
  assign cdb_tag = mul_valid ? mul_tag : held_tag;
  assign cdb_value = mul_valid ? mul_value : held_sum;

endmodule

`default_nettype wire

// ==== design/rs_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_core (
  input  wire logic                             clk,
  input  wire logic                             arst_n,
  input  wire logic                             issue_valid,
  output logic                                  issue_ready,
  input  wire rs_pkg::op_t                      issue_op,
  input  wire logic [rs_pkg::reg_w-1:0]         issue_dest,
  input  wire logic [rs_pkg::reg_w-1:0]         issue_src_a,
  input  wire logic [rs_pkg::reg_w-1:0]         issue_src_b,
  input  wire logic                             has_imm,
  input  wire logic signed [rs_pkg::word_w-1:0] imm,
  input  wire logic [rs_pkg::reg_w-1:0]         rd_addr,
  output logic                                  rd_busy,
  output logic [rs_pkg::word_w-1:0]             rd_value
);

  import rs_pkg::*;

  logic a_busy, b_busy;
  logic [tag_w-1:0] a_tag, b_tag;
  logic [word_w-1:0] a_value, b_value;
  logic rename_en, imm_wr_en;
  logic [reg_w-1:0] rename_reg, imm_wr_reg;
  logic [tag_w-1:0] rename_tag;
  logic signed [word_w-1:0] imm_wr_value;
  logic add_alloc_en, mul_alloc_en;
  operand_u alloc_a, alloc_b;
  logic alloc_a_ready, alloc_b_ready;
  logic add_has_free, mul_has_free;
  logic [idx_w-1:0] add_free_idx, mul_free_idx;
  logic add_disp_valid, add_disp_ready, mul_disp_valid;
  logic [tag_w-1:0] add_disp_tag, mul_disp_tag;
  logic signed [word_w-1:0] add_disp_a, add_disp_b, mul_disp_a, mul_disp_b;
  logic mul_out_valid;
  logic [tag_w-1:0] mul_out_tag;
  logic [word_w-1:0] mul_out_value;
  logic cdb_valid;
  logic [tag_w-1:0] cdb_tag;
  logic [word_w-1:0] cdb_value;

  reg_status_file u_regs (
    .clk, .arst_n, .src_a(issue_src_a), .src_b(issue_src_b),
    .rename_en, .rename_reg, .rename_tag, .imm_wr_en, .imm_wr_reg, .imm_wr_value,
    .cdb_valid, .cdb_tag, .cdb_value, .rd_addr,
    .a_busy, .a_tag, .a_value, .b_busy, .b_tag, .b_value, .rd_busy, .rd_value
  );

  issue_unit u_issue (
    .issue_valid, .issue_op, .issue_dest, .has_imm, .imm,
    .a_busy, .a_tag, .a_value, .b_busy, .b_tag, .b_value,
    .add_has_free, .mul_has_free, .add_free_idx, .mul_free_idx,
    .cdb_valid, .cdb_tag, .cdb_value,
    .issue_ready, .rename_en, .rename_reg, .rename_tag,
    .imm_wr_en, .imm_wr_reg, .imm_wr_value, .add_alloc_en, .mul_alloc_en,
    .alloc_a, .alloc_b, .alloc_a_ready, .alloc_b_ready
  );

  rs_station #(.unit_id(unit_add)) add_rs (
    .clk, .arst_n, .alloc_en(add_alloc_en), .alloc_a, .alloc_b,
    .alloc_a_ready, .alloc_b_ready, .disp_ready(add_disp_ready),
    .cdb_valid, .cdb_tag, .cdb_value,
    .has_free(add_has_free), .free_idx(add_free_idx), .disp_valid(add_disp_valid),
    .disp_tag(add_disp_tag), .disp_a(add_disp_a), .disp_b(add_disp_b)
  );

  rs_station #(.unit_id(unit_mul)) mul_rs (
    .clk, .arst_n, .alloc_en(mul_alloc_en), .alloc_a, .alloc_b,
    .alloc_a_ready, .alloc_b_ready, .disp_ready(1'b1),
    .cdb_valid, .cdb_tag, .cdb_value,
    .has_free(mul_has_free), .free_idx(mul_free_idx), .disp_valid(mul_disp_valid),
    .disp_tag(mul_disp_tag), .disp_a(mul_disp_a), .disp_b(mul_disp_b)
  );

  mul_pipe u_mul (
    .clk, .arst_n, .in_valid(mul_disp_valid), .in_tag(mul_disp_tag),
    .in_a(mul_disp_a), .in_b(mul_disp_b),
    .out_valid(mul_out_valid), .out_tag(mul_out_tag), .out_value(mul_out_value)
  );

  result_bus u_bus (
    .clk, .arst_n, .add_valid(add_disp_valid), .add_tag(add_disp_tag),
    .add_a(add_disp_a), .add_b(add_disp_b),
    .mul_valid(mul_out_valid), .mul_tag(mul_out_tag), .mul_value(mul_out_value),
    .add_ready(add_disp_ready), .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

`default_nettype wire

// ==== project.f ====
common/rs_pkg.sv
design/reg_status_file.sv
design/issue_unit.sv
station/rs_station.sv
design/mul_pipe.sv
design/result_bus.sv
design/rs_core.sv
test/rs_core_properties.sv
test/rs_core_tb.sv

// ==== station/rs_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_station #(
  parameter logic unit_id = rs_pkg::unit_add
) (
  input  wire logic                             clk,
  input  wire logic                             arst_n,
  input  wire logic                             alloc_en,
  input  wire rs_pkg::operand_u                 alloc_a,
  input  wire rs_pkg::operand_u                 alloc_b,
  input  wire logic                             alloc_a_ready,
  input  wire logic                             alloc_b_ready,
  input  wire logic                             disp_ready,
  input  wire logic                             cdb_valid,
  input  wire logic [rs_pkg::tag_w-1:0]         cdb_tag,
  input  wire logic [rs_pkg::word_w-1:0]        cdb_value,
  output logic                                  has_free,
  output logic [rs_pkg::idx_w-1:0]              free_idx,
  output logic                                  disp_valid,
  output logic [rs_pkg::tag_w-1:0]              disp_tag,
  output logic signed [rs_pkg::word_w-1:0]      disp_a,
  output logic signed [rs_pkg::word_w-1:0]      disp_b
);

  import rs_pkg::*;

  localparam int depth = (unit_id == unit_mul) ? mul_depth : add_depth;

  entry_t ent [depth];
  // sent to execution, entry held until its result is broadcast
  logic [depth-1:0] issued;
  logic [idx_w-1:0] sel_idx;
  logic disp_fire;

  always_comb begin
    has_free = 1'b0;
    free_idx = '0;
    disp_valid = 1'b0;
    sel_idx = '0;
    for (int i = depth - 1; i >= 0; i--) begin
      if (!ent[i].busy) begin
        has_free = 1'b1;
        free_idx = idx_w'(i);
      end
      if (ent[i].busy && !issued[i] && ent[i].a_ready && ent[i].b_ready) begin
        disp_valid = 1'b1;
        sel_idx = idx_w'(i);
      end
    end
  end

  assign disp_tag = {unit_id, sel_idx};
  assign disp_a = ent[sel_idx].a.value;
  assign disp_b = ent[sel_idx].b.value;
  assign disp_fire = disp_valid && disp_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < depth; i++) begin
        ent[i] <= '0;
      end
      issued <= '0;
    end else begin
      for (int i = 0; i < depth; i++) begin
        if (alloc_en && free_idx == idx_w'(i)) begin
          ent[i].busy <= 1'b1;
          ent[i].a_ready <= alloc_a_ready;
          ent[i].b_ready <= alloc_b_ready;
          ent[i].a <= alloc_a;
          ent[i].b <= alloc_b;
          issued[i] <= 1'b0;
        end else if (ent[i].busy) begin
          if (disp_fire && sel_idx == idx_w'(i)) begin
            issued[i] <= 1'b1;
          end
          if (issued[i] && cdb_valid && cdb_tag == {unit_id, idx_w'(i)}) begin
            ent[i].busy <= 1'b0;
          end
          // wakeup
          if (!ent[i].a_ready && cdb_valid && ent[i].a.prod.tag == cdb_tag) begin
            ent[i].a.value <= cdb_value;
            ent[i].a_ready <= 1'b1;
          end
          if (!ent[i].b_ready && cdb_valid && ent[i].b.prod.tag == cdb_tag) begin
            ent[i].b.value <= cdb_value;
            ent[i].b_ready <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/rs_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_core_properties (
  input wire logic                       clk,
  input wire logic                       arst_n,
  input wire rs_pkg::op_t                issue_op,
  input wire logic                       has_imm,
  input wire logic                       issue_ready,
  input wire logic                       add_disp_valid,
  input wire logic                       add_disp_ready,
  input wire logic [rs_pkg::tag_w-1:0]   add_disp_tag,
  input wire logic                       mul_disp_valid,
  input wire logic [rs_pkg::tag_w-1:0]   mul_disp_tag,
  input wire logic                       cdb_valid,
  input wire logic [rs_pkg::tag_w-1:0]   cdb_tag
);

  import rs_pkg::*;

  // tags sent to execution and not yet broadcast
  logic [(1 << tag_w)-1:0] in_flight;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_flight <= '0;
    end else begin
      for (int t = 0; t < (1 << tag_w); t++) begin
        if (add_disp_valid && add_disp_ready && add_disp_tag == tag_w'(t)) begin
          in_flight[t] <= 1'b1;
        end else if (mul_disp_valid && mul_disp_tag == tag_w'(t)) begin
          in_flight[t] <= 1'b1;
        end else if (cdb_valid && cdb_tag == tag_w'(t)) begin
          in_flight[t] <= 1'b0;
        end
      end
    end
  end

  cdb_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(cdb_valid))
    else $error("cdb_valid is unknown");

  cdb_tag_dispatched: assert property (@(posedge clk) disable iff (!arst_n)
    cdb_valid |-> in_flight[cdb_tag])
    else $error("cdb_tag %h was never dispatched", cdb_tag);

  imm_move_ready: assert property (@(posedge clk) disable iff (!arst_n)
    (issue_op == op_mv && has_imm) |-> issue_ready)
    else $error("issue_ready low for an immediate move");

endmodule

bind rs_core rs_core_properties u_props (
  .clk, .arst_n, .issue_op, .has_imm, .issue_ready,
  .add_disp_valid, .add_disp_ready, .add_disp_tag,
  .mul_disp_valid, .mul_disp_tag, .cdb_valid, .cdb_tag
);

`default_nettype wire

// ==== test/rs_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_core_tb;

  import rs_pkg::*;

  localparam int half_period = 50;
  localparam int wait_limit = 200;

  logic clk;
  logic arst_n;
  logic issue_valid;
  logic issue_ready;
  op_t issue_op;
  logic [reg_w-1:0] issue_dest;
  logic [reg_w-1:0] issue_src_a;
  logic [reg_w-1:0] issue_src_b;
  logic has_imm;
  logic signed [word_w-1:0] imm;
  logic [reg_w-1:0] rd_addr;
  logic rd_busy;
  logic [word_w-1:0] rd_value;

  logic [word_w-1:0] model [num_regs];
  logic [31:0] lcg_state;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  int stall_cycles;
  bit aborted;

  rs_core DUT (.*);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // program-order result of one operation
  function automatic void model_apply(input op_t op, input logic [reg_w-1:0] dest,
                                      input logic [reg_w-1:0] sa, input logic [reg_w-1:0] sb,
                                      input logic hi, input logic [word_w-1:0] im);
    logic [word_w-1:0] b;
    b = hi ? im : model[sb];
    case (op)
      op_add: model[dest] = model[sa] + b;
      op_mul: model[dest] = model[sa] * b;
      default: model[dest] = hi ? im : model[sa];
    endcase
  endfunction

  // called on a falling edge, returns on a falling edge
  task automatic issue(input op_t op, input logic [reg_w-1:0] dest,
                       input logic [reg_w-1:0] sa, input logic [reg_w-1:0] sb,
                       input logic hi, input logic [word_w-1:0] im);
    int waited;
    bit accepted;
    waited = 0;
    accepted = 1'b0;
    issue_valid = 1'b1;
    issue_op = op;
    issue_dest = dest;
    issue_src_a = sa;
    issue_src_b = sb;
    has_imm = hi;
    imm = im;
    while (!accepted && waited < wait_limit) begin
      #(half_period / 2);
      accepted = issue_ready;
      if (!accepted) begin
        stall_cycles++;
      end
      @(negedge clk);
      waited++;
    end
    issue_valid = 1'b0;
    if (accepted) begin
      model_apply(op, dest, sa, sb, hi, im);
    end else begin
      $display("timeout: operation writing r%0d was never accepted", dest);
      test_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic check_reg(input logic [reg_w-1:0] r, input logic [word_w-1:0] expected);
    int waited;
    waited = 0;
    rd_addr = r;
    #(half_period / 2);
    while (rd_busy && waited < wait_limit) begin
      @(negedge clk);
      #(half_period / 2);
      waited++;
    end
    if (rd_busy) begin
      $display("timeout: r%0d still waits for its result", r);
      test_errors++;
      aborted = 1'b1;
    end else begin
      assert (rd_value == expected) else begin
        $display("error: rd_value of r%0d is %h, expected %h", r, rd_value, expected);
        test_errors++;
      end
    end
    @(negedge clk);
  endtask

  task automatic run_random(input int count);
    logic [31:0] x;
    op_t op;
    logic hi;
    int stalls_before;
    stalls_before = stall_cycles;
    for (int k = 0; k < count && !aborted; k++) begin
      x = lcg_next();
      case (x[31:30])
        2'd0: op = op_add;
        2'd1: op = op_mul;
        default: op = op_mv;
      endcase
      hi = (x[31:30] == 2'd3) || (x[31:30] < 2'd2 && x[17]);
      issue(op, x[29:26], x[25:22], x[21:18], hi, lcg_next());
    end
    assert (stall_cycles != stalls_before) else begin
      $display("issue_ready never went low during the random stream");
      test_errors++;
    end
    for (int r = 0; r < num_regs && !aborted; r++) begin
      check_reg(reg_w'(r), model[r]);
    end
  endtask

  task automatic close_test(input string name);
    if (name != "") begin
      if (test_errors == 0) begin
        $display("test %s: ok", name);
      end else begin
        $display("test %s: %0d errors", name, test_errors);
        tests_failed++;
      end
      tests_run++;
      errors += test_errors;
      test_errors = 0;
    end
  endtask

  initial begin
    int fd;
    int count;
    string line;
    string cmd;
    string name;
    logic [1:0] op;
    logic [reg_w-1:0] dest;
    logic [reg_w-1:0] sa;
    logic [reg_w-1:0] sb;
    logic hi;
    logic [31:0] val;
    arst_n = 1'b0;
    issue_valid = 1'b0;
    issue_op = op_add;
    issue_dest = '0;
    issue_src_a = '0;
    issue_src_b = '0;
    has_imm = 1'b0;
    imm = '0;
    rd_addr = '0;
    lcg_state = 32'h79b199ae;
    name = "";
    for (int r = 0; r < num_regs; r++) begin
      model[r] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    fd = $fopen("test/rs_core_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open test/rs_core_tests.txt");
      errors++;
    end else begin
      while (!aborted && $fgets(line, fd) > 0) begin
        if ($sscanf(line, "%s", cmd) != 1) begin
          cmd = "#";
        end
        case (cmd)
          "t": begin
            close_test(name);
            void'($sscanf(line, "t %s", name));
          end
          "i": begin
            void'($sscanf(line, "i %d %d %d %d %d %h", op, dest, sa, sb, hi, val));
            issue(op_t'(op), dest, sa, sb, hi, val);
          end
          "c": begin
            void'($sscanf(line, "c %d %h", dest, val));
            check_reg(dest, val);
          end
          "r": begin
            void'($sscanf(line, "r %d", count));
            run_random(count);
          end
          default: ;
        endcase
      end
      $fclose(fd);
    end
    close_test(name);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/rs_core_tests.txt ====
# t name | i op dest src_a src_b has_imm imm | c reg value | r count
# op 0 add, 1 mul, 2 move; registers and counts decimal, imm and value hex
t imm_move
i 2 1 0 0 1 0000002a
i 2 2 0 0 1 fffffff9
c 1 0000002a
c 2 fffffff9
t add_mul
i 0 3 1 2 0 00000000
i 1 4 1 2 0 00000000
i 0 5 1 0 1 ffffff00
i 1 6 2 0 1 00000003
i 2 7 0 0 1 7fffffff
i 0 8 7 0 1 00000001
i 2 9 0 0 1 00010001
i 1 10 9 9 0 00000000
c 3 00000023
c 4 fffffeda
c 5 ffffff2a
c 6 ffffffeb
c 8 80000000
c 10 00020001
t chain
i 1 11 4 2 0 00000000
i 0 12 11 1 0 00000000
i 2 13 12 0 0 00000000
c 11 0000080a
c 12 00000834
c 13 00000834
t waw
i 1 14 4 4 0 00000000
i 0 14 1 0 1 00000005
i 0 15 14 0 1 00000001
c 14 0000002f
c 15 00000030
t random
r 60
